// ==== hdl/floor_pkg.sv ====
// Floor request definitions

package floor_pkg;

    //////////////////////////////////////////////////
    // Building size
    //////////////////////////////////////////////////

    // Number of floors served by the car
    localparam int num_floors = 11;

    // Width of a floor number, enough for every served floor
    localparam int floor_width = 4;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    // Floor number, value 0 is the first floor
    typedef logic [floor_width-1:0] floor_t;

    // One bit per floor, bit 0 is the first floor
    typedef logic [num_floors-1:0] floor_mask_t;

    //////////////////////////////////////////////////
    // Constants
    //////////////////////////////////////////////////

    // Lowest floor, target after reset
    localparam floor_t first_floor = floor_t'(0);

    // Highest served floor
    localparam floor_t top_floor = floor_t'(num_floors - 1);

    // Empty request set
    localparam floor_mask_t no_floors = '0;

endpackage

// ==== hdl/request_latch.sv ====
// Request light bank

`timescale 1ns/10ps

module request_latch (
    input  logic                  clock,
    input  logic                  reset_n,
    input  floor_pkg::floor_mask_t buttons,
    input  logic                  service_enable,
    input  floor_pkg::floor_mask_t arrival_mask,
    output floor_pkg::floor_mask_t lights
);

    //////////////////////////////////////////////////
    // Next value of the lights
    //////////////////////////////////////////////////

    floor_pkg::floor_mask_t lights_set;
    floor_pkg::floor_mask_t lights_next;

    // New presses add to the lights already on
    assign lights_set = lights | buttons;

    // The stopped car's floor wins over a press at that floor
    assign lights_next = lights_set & ~arrival_mask;

    //////////////////////////////////////////////////
    // Light register
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= floor_pkg::no_floors;
        end else if (service_enable) begin
            lights <= lights_next;
        end
    end

    // With power off or emergency active the lights simply hold

endmodule

// ==== hdl/car_dispatch.sv ====
// Car dispatch logic

`timescale 1ns/10ps

module car_dispatch (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   power_switch,
    input  logic                   emergency_btn,
    input  floor_pkg::floor_t      current_floor,
    input  logic                   elevator_moving,
    input  floor_pkg::floor_mask_t hall_lights,
    input  floor_pkg::floor_mask_t car_lights,
    output logic                   service_enable,
    output floor_pkg::floor_mask_t arrival_mask,
    output floor_pkg::floor_t      target_floor,
    output logic                   direction_up,
    output logic                   activate
);

    //////////////////////////////////////////////////
    // Internal signals
    //////////////////////////////////////////////////

    logic                   car_stopped;
    logic                   may_serve;
    floor_pkg::floor_mask_t pending;
    logic                   any_pending;
    logic                   target_pending;
    floor_pkg::floor_t      lowest_pending;

    //////////////////////////////////////////////////
    // Service enable and arrival decode
    //////////////////////////////////////////////////

    // Presses and clears only with power on and emergency released
    assign service_enable = power_switch && !emergency_btn;

    assign car_stopped = !elevator_moving;

    // Stopped car with service on may clear lights and take a new target
    assign may_serve = service_enable && car_stopped;

    // One-hot floor of the stopped car
    always_comb begin
        arrival_mask = floor_pkg::no_floors;
        for (int i = 0; i < floor_pkg::num_floors; i++) begin
            if (may_serve && (current_floor == floor_pkg::floor_t'(i))) begin
                arrival_mask[i] = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Pending set
    //////////////////////////////////////////////////

    // Hall calls and car calls count the same
    assign pending = hall_lights | car_lights;

    assign any_pending = |pending;

    // Request still standing at the target
    assign target_pending = pending[target_floor];

    //////////////////////////////////////////////////
    // Lowest floor first priority
    //////////////////////////////////////////////////

    // Scan from the top down so the lowest set bit is taken last
    always_comb begin
        lowest_pending = floor_pkg::first_floor;
        for (int i = floor_pkg::num_floors - 1; i >= 0; i--) begin
            if (pending[i]) begin
                lowest_pending = floor_pkg::floor_t'(i);
            end
        end
    end

    //////////////////////////////////////////////////
    // Target register
    //////////////////////////////////////////////////

    // A new target is picked only once the old one is served
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target_floor <= floor_pkg::first_floor;
        end else if (may_serve && !target_pending && any_pending) begin
            target_floor <= lowest_pending;
        end
    end

    //////////////////////////////////////////////////
    // Requests toward the motion controller
    //////////////////////////////////////////////////

    // Up when the target lies above the car, down otherwise
    assign direction_up = target_floor > current_floor;

    // Move only toward a target that still has a request
    assign activate = may_serve && target_pending &&
                      (target_floor != current_floor);

endmodule

// ==== hdl/floor_controller_top.sv ====
// Floor request controller top

`timescale 1ns/10ps

module floor_controller_top (
    input  logic                   clock,
    input  logic                   reset_n,
    input  floor_pkg::floor_mask_t floor_call_buttons,
    input  floor_pkg::floor_mask_t panel_buttons,
    input  logic                   power_switch,
    input  logic                   emergency_btn,
    input  floor_pkg::floor_t      current_floor,
    input  logic                   elevator_moving,
    output floor_pkg::floor_mask_t call_button_lights,
    output floor_pkg::floor_mask_t panel_button_lights,
    output floor_pkg::floor_t      elevator_floor_selector,
    output logic                   direction_selector,
    output logic                   activate_elevator
);

    //////////////////////////////////////////////////
    // Wires between latches and dispatcher
    //////////////////////////////////////////////////

    logic                   service_enable;
    floor_pkg::floor_mask_t arrival_mask;

    //////////////////////////////////////////////////
    // Request banks
    //////////////////////////////////////////////////

    // Hall call buttons on each landing
    request_latch hall_calls_i (
        .clock          (clock),
        .reset_n        (reset_n),
        .buttons        (floor_call_buttons),
        .service_enable (service_enable),
        .arrival_mask   (arrival_mask),
        .lights         (call_button_lights)
    );

    // Destination buttons inside the car
    request_latch car_calls_i (
        .clock          (clock),
        .reset_n        (reset_n),
        .buttons        (panel_buttons),
        .service_enable (service_enable),
        .arrival_mask   (arrival_mask),
        .lights         (panel_button_lights)
    );

    //////////////////////////////////////////////////
    // Dispatcher
    //////////////////////////////////////////////////

    car_dispatch dispatch_i (
        .clock           (clock),
        .reset_n         (reset_n),
        .power_switch    (power_switch),
        .emergency_btn   (emergency_btn),
        .current_floor   (current_floor),
        .elevator_moving (elevator_moving),
        .hall_lights     (call_button_lights),
        .car_lights      (panel_button_lights),
        .service_enable  (service_enable),
        .arrival_mask    (arrival_mask),
        .target_floor    (elevator_floor_selector),
        .direction_up    (direction_selector),
        .activate        (activate_elevator)
    );

endmodule

// ==== verification/floor_controller_sva.sv ====
// Floor controller assertions

`timescale 1ns/10ps

module floor_controller_sva (
    input logic                   clock,
    input logic                   reset_n,
    input floor_pkg::floor_mask_t floor_call_buttons,
    input floor_pkg::floor_mask_t panel_buttons,
    input logic                   service_enable,
    input logic                   elevator_moving,
    input floor_pkg::floor_mask_t call_button_lights,
    input floor_pkg::floor_mask_t panel_button_lights,
    input floor_pkg::floor_t      elevator_floor_selector,
    input logic                   activate_elevator
);

    floor_pkg::floor_mask_t pending_lights;

    assign pending_lights = call_button_lights | panel_button_lights;

    //////////////////////////////////////////////////
    // Properties
    //////////////////////////////////////////////////

    // Car has to stand still before it is asked to move
    no_activate_while_moving: assert property (
        @(posedge clock) disable iff (!reset_n)
        !(activate_elevator && elevator_moving)
    ) else $error("activate_elevator high while the car is moving");

    // Power off or emergency freezes both banks
    lights_hold_without_service: assert property (
        @(posedge clock) disable iff (!reset_n)
        !service_enable |=> ($stable(call_button_lights) && $stable(panel_button_lights))
    ) else $error("request lights changed while service was disabled");

    // A light only turns on after a press of its own button
    light_set_needs_press: assert property (
        @(posedge clock) disable iff (!reset_n)
        ((call_button_lights & ~$past(call_button_lights) & ~$past(floor_call_buttons)) |
         (panel_button_lights & ~$past(panel_button_lights) & ~$past(panel_buttons)))
        == floor_pkg::no_floors
    ) else $error("request light turned on without a press");

    activate_needs_pending_target: assert property (
        @(posedge clock) disable iff (!reset_n)
        activate_elevator |-> pending_lights[elevator_floor_selector]
    ) else $error("activate_elevator high for a target with no request");

endmodule

// ==== verification/floor_controller_checker.sv ====
// Floor controller checker

`timescale 1ns/10ps

module floor_controller_checker (
    input  logic                   clock,
    input  logic                   reset_n,
    input  floor_pkg::floor_mask_t floor_call_buttons,
    input  floor_pkg::floor_mask_t panel_buttons,
    input  logic                   power_switch,
    input  logic                   emergency_btn,
    input  floor_pkg::floor_t      current_floor,
    input  logic                   elevator_moving,
    input  floor_pkg::floor_mask_t call_button_lights,
    input  floor_pkg::floor_mask_t panel_button_lights,
    input  floor_pkg::floor_t      elevator_floor_selector,
    input  logic                   direction_selector,
    input  logic                   activate_elevator,
    output int                     error_count
);

    //////////////////////////////////////////////////
    // Reference model state
    //////////////////////////////////////////////////

    floor_pkg::floor_mask_t exp_hall;
    floor_pkg::floor_mask_t exp_car;
    floor_pkg::floor_t      exp_target;
    floor_pkg::floor_mask_t pending;
    floor_pkg::floor_mask_t arrival;
    floor_pkg::floor_t      lowest;
    logic                   found;
    logic                   service;
    logic                   stopped;
    logic                   exp_activate;
    logic                   exp_up;
    int                     error_count_q = 0;

    assign error_count = error_count_q;

    assign service      = power_switch && !emergency_btn;
    assign stopped      = !elevator_moving;
    assign pending      = exp_hall | exp_car;
    assign exp_activate = service && stopped && pending[exp_target] &&
                          (exp_target != current_floor);
    assign exp_up       = exp_target > current_floor;

    // Floor where the stopped car clears its lights
    always_comb begin
        arrival = floor_pkg::no_floors;
        if (service && stopped) begin
            arrival[current_floor] = 1'b1;
        end
    end

    // First pending floor counting up from the bottom
    always_comb begin
        lowest = floor_pkg::first_floor;
        found  = 1'b0;
        for (int i = 0; i < floor_pkg::num_floors; i++) begin
            if (!found && pending[i]) begin
                lowest = floor_pkg::floor_t'(i);
                found  = 1'b1;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, expected);
            error_count_q++;
        end
    endtask

    //////////////////////////////////////////////////
    // Compare, then advance the model
    //////////////////////////////////////////////////

    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            exp_hall   <= floor_pkg::no_floors;
            exp_car    <= floor_pkg::no_floors;
            exp_target <= floor_pkg::first_floor;
        end else begin
            check_value("call_button_lights", 32'(call_button_lights), 32'(exp_hall));
            check_value("panel_button_lights", 32'(panel_button_lights), 32'(exp_car));
            check_value("elevator_floor_selector", 32'(elevator_floor_selector),
                        32'(exp_target));
            check_value("direction_selector", 32'(direction_selector), 32'(exp_up));
            check_value("activate_elevator", 32'(activate_elevator), 32'(exp_activate));
            if (service) begin
                exp_hall <= (exp_hall | floor_call_buttons) & ~arrival;
                exp_car  <= (exp_car | panel_buttons) & ~arrival;
            end
            if (service && stopped && !pending[exp_target] && found) begin
                exp_target <= lowest;
            end
        end
    end

endmodule

// ==== verification/tb_floor_controller.sv ====
// Floor controller testbench

`timescale 1ns/10ps

module tb_floor_controller;

    localparam int run_cycles       = 4000;
    localparam int activate_timeout = 400;

    logic                   clock;
    logic                   reset_n;
    floor_pkg::floor_mask_t floor_call_buttons;
    floor_pkg::floor_mask_t panel_buttons;
    logic                   power_switch;
    logic                   emergency_btn;
    floor_pkg::floor_t      current_floor;
    logic                   elevator_moving;
    floor_pkg::floor_mask_t call_button_lights;
    floor_pkg::floor_mask_t panel_button_lights;
    floor_pkg::floor_t      elevator_floor_selector;
    logic                   direction_selector;
    logic                   activate_elevator;

    integer seed;
    int     cycle_count;
    int     timeout_count;
    int     mismatch_count;
    int     power_off_left;
    int     emergency_left;
    logic   timed_out;

    //////////////////////////////////////////////////
    // DUT, checker and assertions
    //////////////////////////////////////////////////

    floor_controller_top dut_i (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .floor_call_buttons      (floor_call_buttons),
        .panel_buttons           (panel_buttons),
        .power_switch            (power_switch),
        .emergency_btn           (emergency_btn),
        .current_floor           (current_floor),
        .elevator_moving         (elevator_moving),
        .call_button_lights      (call_button_lights),
        .panel_button_lights     (panel_button_lights),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator)
    );

    floor_controller_checker check_i (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .floor_call_buttons      (floor_call_buttons),
        .panel_buttons           (panel_buttons),
        .power_switch            (power_switch),
        .emergency_btn           (emergency_btn),
        .current_floor           (current_floor),
        .elevator_moving         (elevator_moving),
        .call_button_lights      (call_button_lights),
        .panel_button_lights     (panel_button_lights),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .error_count             (mismatch_count)
    );

    bind floor_controller_top floor_controller_sva sva_i (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .floor_call_buttons      (floor_call_buttons),
        .panel_buttons           (panel_buttons),
        .service_enable          (service_enable),
        .elevator_moving         (elevator_moving),
        .call_button_lights      (call_button_lights),
        .panel_button_lights     (panel_button_lights),
        .elevator_floor_selector (elevator_floor_selector),
        .activate_elevator       (activate_elevator)
    );

    always #10 clock = ~clock;

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // One-cycle presses, rare power drops and emergency presses
    task automatic drive_buttons();
        floor_pkg::floor_mask_t hall_press;
        floor_pkg::floor_mask_t car_press;
        int                     press;
        hall_press = floor_pkg::no_floors;
        car_press  = floor_pkg::no_floors;
        if ({$random(seed)} % 4 == 0) begin
            press      = {$random(seed)} % floor_pkg::num_floors;
            hall_press = floor_pkg::floor_mask_t'(1) << press;
        end
        if ({$random(seed)} % 5 == 0) begin
            press     = {$random(seed)} % floor_pkg::num_floors;
            car_press = floor_pkg::floor_mask_t'(1) << press;
        end
        floor_call_buttons <= hall_press;
        panel_buttons      <= car_press;
        if (power_off_left > 0) begin
            power_off_left--;
        end else if ({$random(seed)} % 100 == 0) begin
            power_off_left = 2 + {$random(seed)} % 5;
        end
        if (emergency_left > 0) begin
            emergency_left--;
        end else if ({$random(seed)} % 120 == 0) begin
            emergency_left = 1 + {$random(seed)} % 4;
        end
        power_switch  <= (power_off_left == 0);
        emergency_btn <= (emergency_left != 0);
    endtask

    task automatic next_cycle();
        @(posedge clock);
        cycle_count++;
        drive_buttons();
    endtask

    task automatic wait_for_activate();
        int waited;
        waited = 0;
        while (!activate_elevator && !timed_out && cycle_count < run_cycles) begin
            next_cycle();
            waited++;
            if (!activate_elevator && waited >= activate_timeout) begin
                $display("ERROR at %0t: activate_elevator stayed low for %0d cycles",
                         $time, waited);
                timeout_count++;
                timed_out = 1'b1;
            end
        end
    endtask

    // Simple car, travels a few cycles and steps one floor
    task automatic move_car();
        int   travel;
        logic going_up;
        going_up = direction_selector;
        travel   = 2 + {$random(seed)} % 4;
        elevator_moving <= 1'b1;
        repeat (travel) next_cycle();
        elevator_moving <= 1'b0;
        if (going_up) begin
            current_floor <= current_floor + floor_pkg::floor_t'(1);
        end else begin
            current_floor <= current_floor - floor_pkg::floor_t'(1);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        seed               = 32'hf2f7_a028;
        clock              = 1'b0;
        reset_n            = 1'b0;
        floor_call_buttons = floor_pkg::no_floors;
        panel_buttons      = floor_pkg::no_floors;
        power_switch       = 1'b1;
        emergency_btn      = 1'b0;
        current_floor      = floor_pkg::first_floor;
        elevator_moving    = 1'b0;
        cycle_count        = 0;
        timeout_count      = 0;
        power_off_left     = 0;
        emergency_left     = 0;
        timed_out          = 1'b0;

        repeat (3) @(posedge clock);
        reset_n <= 1'b1;

        while (cycle_count < run_cycles && !timed_out) begin
            wait_for_activate();
            if (activate_elevator && !timed_out && cycle_count < run_cycles) begin
                move_car();
            end
        end

        // Let the checker finish the last edge
        @(negedge clock);
        $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
hdl/floor_pkg.sv
hdl/request_latch.sv
hdl/car_dispatch.sv
hdl/floor_controller_top.sv
verification/floor_controller_sva.sv
verification/floor_controller_checker.sv
verification/tb_floor_controller.sv

// ==== Makefile ====
# Verilator build and run for the floor request controller

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_floor_controller
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check for the pass line"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "TEST PASSED"; \
	else \
		echo "TEST FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
